// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

  ////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////
  localparam int tag_w      = 22;
  localparam int index_w    = 4;
  localparam int offset_w   = 4;  // Word within a line
  localparam int num_ways   = 4;
  localparam int way_w      = 2;
  localparam int line_words = 16;

  typedef logic [1:0] age_t;  // Larger is older

  ////////////////////////////////////////////////////////////
  // Address word as a whole or split into fields
  ////////////////////////////////////////////////////////////
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] word;
      logic [1:0]          byte_off;
    } fields;
  } addr_t;

endpackage

`default_nettype wire

// ==== hdl/tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_array (
  input  wire                            clk,
  input  wire                            rst,
  input  wire [dcache_pkg::index_w-1:0]  index,
  input  wire [dcache_pkg::tag_w-1:0]    tag,
  input  wire                            tag_we,
  input  wire                            dirty_set,
  input  wire                            dirty_clr,
  input  wire [dcache_pkg::way_w-1:0]    way,
  input  wire dcache_pkg::age_t [dcache_pkg::num_ways-1:0] ages,
  output logic                           hit,
  output logic [dcache_pkg::way_w-1:0]   hit_way,
  output logic [dcache_pkg::way_w-1:0]   victim_way,
  output logic                           victim_dirty,
  output logic [dcache_pkg::tag_w-1:0]   victim_tag
);
  import dcache_pkg::*;

  logic [tag_w-1:0] tag_mem [2**index_w][num_ways];
  logic [2**index_w-1:0][num_ways-1:0] valid;
  logic [2**index_w-1:0][num_ways-1:0] dirty;
  logic [num_ways-1:0] hits;

  always_ff @(posedge clk)
  begin
    if (tag_we)
      tag_mem[index][way] <= tag;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else
    begin
      if (tag_we)
        valid[index][way] <= 1'b1;
      if (dirty_set)
        dirty[index][way] <= 1'b1;
      else if (dirty_clr)
        dirty[index][way] <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Lookup and replacement choice
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
      hits[w] = valid[index][w] && (tag_mem[index][w] == tag);
  end

  assign hit = |hits;

  always_comb
  begin
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--)
      if (hits[w])
        hit_way = way_w'(w);
  end

  always_comb
  begin
    victim_way = '0;
    for (int w = 1; w < num_ways; w++)  // Oldest way wins and a tie goes low
      if (ages[w] > ages[victim_way])
        victim_way = way_w'(w);
    for (int w = num_ways - 1; w >= 0; w--)  // Free way beats any age
      if (!valid[index][w])
        victim_way = way_w'(w);
  end

  assign victim_dirty = dirty[index][victim_way];
  assign victim_tag   = tag_mem[index][victim_way];

  // A refill never installs a tag the set already holds
  a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hits));

endmodule

`default_nettype wire

// ==== hdl/lru_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module lru_array (
  input  wire                           clk,
  input  wire                           rst,
  input  wire [dcache_pkg::index_w-1:0] index,
  input  wire                           touch,
  input  wire [dcache_pkg::way_w-1:0]   way,
  output dcache_pkg::age_t [dcache_pkg::num_ways-1:0] ages
);
  import dcache_pkg::*;

  age_t [2**index_w-1:0][num_ways-1:0] age_mem;
  age_t [num_ways-1:0] next_ages;

  assign ages = age_mem[index];

  ////////////////////////////////////////////////////////////
  // Age update on an access
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
    begin
      if (w == way)
        next_ages[w] = '0;  // Most recent
      else if (ages[w] <= ages[way])
        next_ages[w] = age_t'(ages[w] + 1'b1);  // Wraps at 3
      else
        next_ages[w] = ages[w];
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      age_mem <= '0;
    end
    else if (touch)
    begin
      age_mem[index] <= next_ages;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_array (
  input  wire                            clk,
  input  wire [dcache_pkg::index_w-1:0]  index,
  input  wire [dcache_pkg::way_w-1:0]    way,
  input  wire [dcache_pkg::offset_w-1:0] word,
  input  wire [3:0]                      wbyte,
  input  wire [31:0]                     wdata,
  output logic [31:0]                    rdata
);
  import dcache_pkg::*;

  // Way, set, word
  logic [31:0] mem [num_ways][2**index_w][line_words];

  ////////////////////////////////////////////////////////////
  // Byte-enable write, combinational read
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < 4; b++)
    begin
      if (wbyte[b])
        mem[way][index][word][8*b +: 8] <= wdata[8*b +: 8];
    end
  end

  // Old word during a write cycle
  assign rdata = mem[way][index][word];

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  wire                             clk,
  input  wire                             rst,
  // CPU
  input  wire [31:0]                      addr,
  input  wire [31:0]                      din,
  input  wire                             req,
  input  wire                             wreq,
  input  wire [3:0]                       wbyte,
  output logic [31:0]                     dout,
  output logic                            ok,
  output logic                            miss,
  // Memory
  output logic                            sen,
  output logic [31:0]                     raddr,
  input  wire [31:0]                      sdata,
  input  wire                             rdata_ok,
  output logic                            wen,
  output logic [31:0]                     waddr,
  output logic [31:0]                     wdata,
  input  wire                             wdata_ok,
  // Arrays
  output logic [dcache_pkg::index_w-1:0]  index,
  output logic [dcache_pkg::tag_w-1:0]    tag,
  output logic                            tag_we,
  output logic                            dirty_set,
  output logic                            dirty_clr,
  output logic [dcache_pkg::way_w-1:0]    way,
  input  wire                             hit,
  input  wire [dcache_pkg::way_w-1:0]     hit_way,
  input  wire [dcache_pkg::way_w-1:0]     victim_way,
  input  wire                             victim_dirty,
  input  wire [dcache_pkg::tag_w-1:0]     victim_tag,
  output logic                            touch,
  output logic [dcache_pkg::offset_w-1:0] word,
  output logic [3:0]                      line_wbyte,
  output logic [31:0]                     line_wdata,
  input  wire [31:0]                      line_rdata
);
  import dcache_pkg::*;

  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_write_back = 3'd1;
  localparam logic [2:0] st_refill     = 3'd2;
  localparam logic [2:0] st_fill_tag   = 3'd3;
  localparam logic [2:0] st_respond    = 3'd4;

  logic [2:0]          state;
  logic [offset_w-1:0] cnt;  // Burst word
  addr_t               req_addr;
  addr_t               cur_addr;
  addr_t               wb_base;
  addr_t               rf_base;
  logic [31:0]         req_din;
  logic                req_wreq;
  logic [3:0]          req_wbyte;
  logic [way_w-1:0]    vic_way;
  logic [tag_w-1:0]    vic_tag;
  logic                hit_access;
  logic [31:0]         merged;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++)
      if (be[b])
        res[8*b +: 8] = new_word[8*b +: 8];
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Array addressing
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    cur_addr = req_addr;
    if (state == st_idle)
      cur_addr.raw = addr;  // Lookup straight from the CPU
  end

  assign index      = cur_addr.fields.index;
  assign tag        = cur_addr.fields.tag;
  assign hit_access = (state == st_idle) && req && hit;
  assign way        = (state == st_idle) ? hit_way : vic_way;
  assign word       = (state == st_write_back || state == st_refill) ? cnt
                                                                     : cur_addr.fields.word;
  assign line_wdata = (state == st_refill) ? sdata : ((state == st_idle) ? din : req_din);

  always_comb
  begin
    line_wbyte = 4'b0000;
    case (state)
      st_idle:
        if (hit_access && wreq)
          line_wbyte = wbyte;
      st_refill:
        if (rdata_ok)
          line_wbyte = 4'b1111;
      st_respond:
        if (req_wreq)
          line_wbyte = req_wbyte;
      default:
        line_wbyte = 4'b0000;
    endcase
  end

  assign merged    = merge_bytes(line_rdata, line_wdata, line_wbyte);
  assign touch     = hit_access || (state == st_respond);
  assign dirty_set = (hit_access && wreq) || (state == st_respond && req_wreq);
  assign tag_we    = (state == st_fill_tag);
  assign dirty_clr = (state == st_fill_tag);

  ////////////////////////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    wb_base                 = req_addr;
    wb_base.fields.tag      = vic_tag;
    wb_base.fields.word     = '0;
    wb_base.fields.byte_off = '0;
    rf_base                 = req_addr;
    rf_base.fields.word     = '0;
    rf_base.fields.byte_off = '0;
  end

  assign waddr = wb_base.raw;
  assign raddr = rf_base.raw;
  assign wdata = line_rdata;  // Victim word at cnt
  assign wen   = (state == st_write_back);
  assign sen   = (state == st_refill);
  assign miss  = (state == st_write_back) || (state == st_refill);

  ////////////////////////////////////////////////////////////
  // Main FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= st_idle;
      cnt   <= '0;
      ok    <= 1'b0;
    end
    else
    begin
      ok <= hit_access || (state == st_respond);
      case (state)
        st_idle:
          if (req && !hit)
            state <= victim_dirty ? st_write_back : st_refill;
        st_write_back:
          if (wdata_ok)
          begin
            cnt <= cnt + 1'b1;
            if (cnt == offset_w'(line_words - 1))
              state <= st_refill;
          end
        st_refill:
          if (rdata_ok)
          begin
            cnt <= cnt + 1'b1;
            if (cnt == offset_w'(line_words - 1))
              state <= st_fill_tag;
          end
        st_fill_tag:
          state <= st_respond;
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_idle && req)
    begin
      req_addr.raw <= addr;
      req_din      <= din;
      req_wreq     <= wreq;
      req_wbyte    <= wbyte;
      vic_way      <= victim_way;
      vic_tag      <= victim_tag;
    end
    if (hit_access || state == st_respond)
      dout <= merged;  // Read word or merged write
  end

  a_req_idle: assert property (@(posedge clk) disable iff (rst) req |-> state == st_idle);
  // Memory strobes only answer a burst in progress
  a_strobe_en: assert property (@(posedge clk) disable iff (rst)
                                (!wdata_ok || wen) && (!rdata_ok || sen));

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  wire        clk,
  input  wire        rst,
  input  wire [31:0] addr,
  input  wire [31:0] din,
  input  wire        req,
  input  wire        wreq,
  input  wire [3:0]  wbyte,
  output wire [31:0] dout,
  output wire        ok,
  output wire        miss,
  output wire        sen,
  output wire [31:0] raddr,
  input  wire [31:0] sdata,
  input  wire        rdata_ok,
  output wire        wen,
  output wire [31:0] waddr,
  output wire [31:0] wdata,
  input  wire        wdata_ok
);
  import dcache_pkg::*;

  wire [index_w-1:0]  index;
  wire [tag_w-1:0]    tag;
  wire                tag_we;
  wire                dirty_set;
  wire                dirty_clr;
  wire [way_w-1:0]    way;
  wire age_t [num_ways-1:0] ages;
  wire                hit;
  wire [way_w-1:0]    hit_way;
  wire [way_w-1:0]    victim_way;
  wire                victim_dirty;
  wire [tag_w-1:0]    victim_tag;
  wire                touch;
  wire [offset_w-1:0] word;
  wire [3:0]          line_wbyte;
  wire [31:0]         line_wdata;
  wire [31:0]         line_rdata;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  tag_array u_tag_array (
    .clk, .rst, .index, .tag, .tag_we, .dirty_set, .dirty_clr, .way, .ages,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
  );

  lru_array u_lru_array (.clk, .rst, .index, .touch, .way, .ages);

  data_array u_data_array (
    .clk, .index, .way, .word,
    .wbyte(line_wbyte), .wdata(line_wdata), .rdata(line_rdata)
  );

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////
  cache_ctrl u_cache_ctrl (
    .clk, .rst, .addr, .din, .req, .wreq, .wbyte, .dout, .ok, .miss,
    .sen, .raddr, .sdata, .rdata_ok, .wen, .waddr, .wdata, .wdata_ok,
    .index, .tag, .tag_we, .dirty_set, .dirty_clr, .way,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
    .touch, .word, .line_wbyte, .line_wdata, .line_rdata
  );

endmodule

`default_nettype wire

// ==== tb/dcache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
  input  wire        clk,
  input  wire        rst,
  input  wire [31:0] addr,
  input  wire [31:0] din,
  input  wire        req,
  input  wire        wreq,
  input  wire [3:0]  wbyte,
  input  wire [31:0] dout,
  input  wire        ok,
  input  wire        miss,
  input  wire        sen,
  input  wire [31:0] raddr,
  input  wire        wen,
  input  wire [31:0] waddr,
  input  wire [31:0] wdata,
  input  wire        wdata_ok,
  input  wire        rdata_ok,
  output int         errors
);

  // Shadow cache state and the CPU view of memory
  logic [21:0] sh_tag   [16][4];
  logic        sh_valid [16][4];
  logic        sh_dirty [16][4];
  logic [1:0]  sh_age   [16][4];
  logic [31:0] arch     [2048];

  logic        pending;
  logic        exp_hit;
  logic        exp_wb;
  logic [1:0]  exp_way;
  logic [31:0] exp_dout;
  logic [31:0] exp_wb_base;
  logic [31:0] exp_rf_base;
  logic        sen_q;
  int          lat;
  int          wb_cnt;
  int          rf_cnt;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    errors = errors + 1;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors = errors + 1;
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] predict(input logic [31:0] a, input logic [31:0] d,
                                          input logic w, input logic [3:0] be,
                                          output logic h, output logic [1:0] v);
    logic [31:0] val;
    logic        found_free;
    int          ix;
    ix = a[9:6];
    h  = 1'b0;
    v  = 2'd0;
    for (int k = 0; k < 4; k++)
      if (sh_valid[ix][k] && sh_tag[ix][k] == a[31:10])
      begin
        h = 1'b1;
        v = 2'(k);
      end
    if (!h)
    begin
      found_free = 1'b0;
      for (int k = 0; k < 4; k++)
        if (!found_free && !sh_valid[ix][k])
        begin
          found_free = 1'b1;
          v = 2'(k);
        end
      for (int k = 1; k < 4; k++)  // Oldest way wins and the lowest takes a tie
        if (!found_free && sh_age[ix][k] > sh_age[ix][v])
          v = 2'(k);
    end
    val = arch[a[12:2]];
    for (int b = 0; b < 4; b++)
      if (w && be[b])
        val[8*b +: 8] = d[8*b +: 8];
    return val;
  endfunction

  task automatic update_shadow(input logic [31:0] a, input logic w, input logic h,
                               input logic [1:0] v, input logic [31:0] word_val);
    logic [1:0] touched;
    int         ix;
    ix = a[9:6];
    if (!h)
    begin
      sh_tag[ix][v]   = a[31:10];
      sh_valid[ix][v] = 1'b1;
      sh_dirty[ix][v] = 1'b0;
    end
    touched = sh_age[ix][v];
    for (int k = 0; k < 4; k++)
      if (k == v)
        sh_age[ix][k] = 2'd0;
      else if (sh_age[ix][k] <= touched)
        sh_age[ix][k] = sh_age[ix][k] + 2'd1;  // Wraps
    if (w)
    begin
      sh_dirty[ix][v] = 1'b1;
      arch[a[12:2]]   = word_val;
    end
  endtask

  initial
  begin
    errors = 0;
    for (int i = 0; i < 2048; i++)
      arch[i] = i ^ 32'h5a5a_0000;
  end

  ////////////////////////////////////////////////////////////
  // Response and memory traffic compare
  ////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int ix = 0; ix < 16; ix++)
        for (int k = 0; k < 4; k++)
        begin
          sh_valid[ix][k] = 1'b0;
          sh_dirty[ix][k] = 1'b0;
          sh_age[ix][k]   = 2'd0;
        end
      pending = 1'b0;
      sen_q   = 1'b0;
    end
    else
    begin
      if (pending)
      begin
        lat = lat + 1;
        if (lat == 1)
        begin
          if (ok !== exp_hit)
            report_mismatch("ok", ok, exp_hit);
          if (miss !== !exp_hit)
            report_mismatch("miss", miss, !exp_hit);
        end
        if (sen && !sen_q && raddr !== exp_rf_base)
          report_mismatch("raddr", raddr, exp_rf_base);
        if (wen && wdata_ok && exp_wb)
        begin
          if (waddr !== exp_wb_base)
            report_mismatch("waddr", waddr, exp_wb_base);
          if (wdata !== arch[exp_wb_base[12:2] + wb_cnt])
            report_mismatch("wdata", wdata, arch[exp_wb_base[12:2] + wb_cnt]);
        end
        if (wen && wdata_ok)
          wb_cnt = wb_cnt + 1;
        if (sen && rdata_ok)
          rf_cnt = rf_cnt + 1;
        if (ok)
        begin
          if (dout !== exp_dout)
            report_mismatch("dout", dout, exp_dout);
          if (wb_cnt != (exp_wb ? 16 : 0))
            report_mismatch("wdata_ok count", wb_cnt, exp_wb ? 16 : 0);
          if (rf_cnt != (exp_hit ? 0 : 16))
            report_mismatch("rdata_ok count", rf_cnt, exp_hit ? 0 : 16);
          pending = 1'b0;
        end
        else if (lat > 1000)
        begin
          report_problem("no ok within 1000 cycles of a request");
          pending = 1'b0;
        end
      end
      if (req)
      begin
        if (pending)
          report_problem("request issued before the previous ok");
        exp_dout    = predict(addr, din, wreq, wbyte, exp_hit, exp_way);
        exp_wb      = !exp_hit && sh_dirty[addr[9:6]][exp_way];
        exp_wb_base = {sh_tag[addr[9:6]][exp_way], addr[9:6], 6'b0};
        exp_rf_base = {addr[31:6], 6'b0};
        update_shadow(addr, wreq, exp_hit, exp_way, exp_dout);
        pending = 1'b1;
        lat     = 0;
        wb_cnt  = 0;
        rf_cnt  = 0;
      end
      sen_q = sen;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

  localparam int num_requests = 400;
  localparam int max_cycles   = num_requests * 200;
  localparam int mem_words    = 2048;  // 8 tags worth of lines

  logic        clk;
  logic        rst;
  logic [31:0] addr;
  logic [31:0] din;
  logic        req;
  logic        wreq;
  logic [3:0]  wbyte;
  wire  [31:0] dout;
  wire         ok;
  wire         miss;
  wire         sen;
  wire  [31:0] raddr;
  logic [31:0] sdata;
  logic        rdata_ok;
  wire         wen;
  wire  [31:0] waddr;
  wire  [31:0] wdata;
  logic        wdata_ok;
  int          errors;

  logic [31:0] mem [mem_words];
  logic [31:0] stim_seed;
  logic [31:0] mem_seed;
  int          rd_cnt;
  int          wr_cnt;
  int          cycles;

  dcache_top u_dcache_top (.*);

  dcache_checker u_checker (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] make_addr(input int t, input int ix, input int w);
    return {22'(t), 4'(ix), 4'(w), 2'b00};
  endfunction

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Memory model with random strobe stalls
  ////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    if (rst)
    begin
      rdata_ok <= 1'b0;
      wdata_ok <= 1'b0;
      rd_cnt = 0;
      wr_cnt = 0;
    end
    else
    begin
      mem_seed = lcg_next(mem_seed);
      if (wen && wdata_ok)
      begin
        mem[waddr[12:2] + wr_cnt] = wdata;
        wr_cnt = wr_cnt + 1;
      end
      if (sen && rdata_ok)
        rd_cnt = rd_cnt + 1;
      if (!wen)
        wr_cnt = 0;
      if (!sen)
        rd_cnt = 0;
      wdata_ok <= wen && (wr_cnt < 16) && (mem_seed[17:16] != 2'b00);
      rdata_ok <= sen && (rd_cnt < 16) && (mem_seed[19:18] != 2'b00);
      if (sen && rd_cnt < 16)
        sdata <= mem[raddr[12:2] + rd_cnt];  // Word 0 first
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("Timeout after %0d cycles, the cache stopped responding", cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic send_request(input logic [31:0] a, input logic [31:0] d,
                              input logic w, input logic [3:0] be);
    @(posedge clk);
    addr  <= a;
    din   <= d;
    wreq  <= w;
    wbyte <= be;
    req   <= 1'b1;
    @(posedge clk);
    req <= 1'b0;
    while (!ok)
      @(posedge clk);
  endtask

  task automatic random_request();
    logic [31:0] r_addr;
    logic [31:0] r_data;
    logic [31:0] r_ctl;
    stim_seed = lcg_next(stim_seed);
    r_addr = stim_seed;
    stim_seed = lcg_next(stim_seed);
    r_data = stim_seed;
    stim_seed = lcg_next(stim_seed);
    r_ctl = stim_seed;
    send_request(make_addr(r_addr[30:28], r_addr[27:20] % 3, r_addr[19:16]),
                 r_data, r_ctl[29], r_ctl[27:24]);
  endtask

  initial
  begin
    clk       = 1'b0;
    rst       = 1'b1;
    addr      = '0;
    din       = '0;
    req       = 1'b0;
    wreq      = 1'b0;
    wbyte     = '0;
    sdata     = '0;
    rdata_ok  = 1'b0;
    wdata_ok  = 1'b0;
    stim_seed = 32'd58761;
    mem_seed  = 32'd58761;
    cycles    = 0;
    for (int i = 0; i < mem_words; i++)
      mem[i] = i ^ 32'h5a5a_0000;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Cold miss, hit, partial write, readback
    send_request(make_addr(0, 0, 3), 32'h0, 1'b0, 4'b0000);
    send_request(make_addr(0, 0, 3), 32'h0, 1'b0, 4'b0000);
    send_request(make_addr(0, 0, 3), 32'hdead_beef, 1'b1, 4'b0101);
    send_request(make_addr(0, 0, 3), 32'h0, 1'b0, 4'b0000);
    send_request(make_addr(1, 0, 5), 32'hcafe_f00d, 1'b1, 4'b1100);  // Write allocate
    // Fill set 0, then evict both dirty lines
    for (int t = 2; t < 6; t++)
      send_request(make_addr(t, 0, t), 32'h0, 1'b0, 4'b0000);
    send_request(make_addr(0, 0, 3), 32'h0, 1'b0, 4'b0000);
    repeat (num_requests - 10) random_request();

    repeat (2) @(posedge clk);
    $display("Requests: %0d, errors: %0d", num_requests, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/dcache_pkg.sv
hdl/tag_array.sv
hdl/lru_array.sv
hdl/data_array.sv
hdl/cache_ctrl.sv
hdl/dcache_top.sv
tb/dcache_checker.sv
tb/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - hdl/dcache_pkg.sv
      - hdl/tag_array.sv
      - hdl/lru_array.sv
      - hdl/data_array.sv
      - hdl/cache_ctrl.sv
      - hdl/dcache_top.sv
  - target: simulation
    files:
      - tb/dcache_checker.sv
      - tb/tb_dcache.sv
